//--- filelist.f
+incdir+logic
logic/mips_pkg.sv
logic/alu.sv
logic/multDiv.sv
logic/forwardUnit.sv
logic/operandSelect.sv
logic/execute.sv
logic/executeStage.sv
verification/executeStage_checker.sv
verification/executeStageTb.sv

//--- logic/alu.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module alu import mips_pkg::*; (
    input  word_t    a,
    input  word_t    b,
    input  aluFunc_t func,
    output word_t    result,
    output logic     overflow
);

    word_t sum;
    word_t diff;
    logic  addOvf;
    logic  subOvf;
    logic  [4:0] sa;

    assign sum  = a + b;
    assign diff = a - b;

    // shift amount taken from operand a
    assign sa = a[4:0];

    // same-sign operands with a result of the other sign
    assign addOvf = (a[`MIPS_WORD_BITS-1] == b[`MIPS_WORD_BITS-1]) &&
                    (sum[`MIPS_WORD_BITS-1] != a[`MIPS_WORD_BITS-1]);

    // opposite-sign operands, result sign flips away from a
    assign subOvf = (a[`MIPS_WORD_BITS-1] != b[`MIPS_WORD_BITS-1]) &&
                    (diff[`MIPS_WORD_BITS-1] != a[`MIPS_WORD_BITS-1]);

    always_comb begin
        case (func)
            aluAdd, aluAddu: result = sum;
            aluSub, aluSubu: result = diff;
            aluAnd:          result = a & b;
            aluOr:           result = a | b;
            aluXor:          result = a ^ b;
            aluNor:          result = ~(a | b);
            aluSll:          result = b << sa;
            aluSrl:          result = b >> sa;
            aluSra:          result = word_t'($signed(b) >>> sa);
            aluSlt:          result = word_t'($signed(a) < $signed(b));
            aluSltu:         result = word_t'(a < b);
            // upper half from the immediate
            aluLui:          result = {b[15:0], 16'h0000};
            default:         result = '0;
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        case (func)
            aluAdd:  overflow = addOvf;
            aluSub:  overflow = subOvf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

//--- logic/execute.sv
`timescale 1ns/1ps

module execute import mips_pkg::*; (
    input  logic       validE,
    input  aluFunc_t   aluFuncE,
    input  aluSrcB_t   aluSrcBE,
    input  logic       shamtValidE,
    input  regDst_t    regDstE,
    input  logic       jumpE,
    input  logic       regWriteE,
    input  decodedOp_t opE,
    input  regAddr_t   rtE,
    input  regAddr_t   rdE,
    input  logic [4:0] shamtE,
    input  word_t      immE,
    input  word_t      srcAE,
    input  word_t      srcBE,
    input  word_t      pcPlus4E,
    input  forward_t   forwardA,
    input  forward_t   forwardB,
    input  word_t      aluOutM,
    input  word_t      resultW,
    output word_t      aluOut,
    output word_t      writeData,
    output regAddr_t   writeReg,
    output logic       regWrite,
    output word_t      hi,
    output word_t      lo,
    output logic       hiLoWrite,
    output logic       overflow
);

    word_t aluA;
    word_t aluB;
    word_t aluResult;
    logic  aluOverflow;
    logic  mdActive;

    operandSelect u_operandSelect (
        .srcA(srcAE), .srcB(srcBE), .aluOutM(aluOutM), .resultW(resultW), .imm(immE),
        .forwardA(forwardA), .forwardB(forwardB), .shamt(shamtE), .shamtValid(shamtValidE),
        .aluSrcB(aluSrcBE), .rt(rtE), .rd(rdE), .regDst(regDstE), .jump(jumpE),
        .aluA(aluA), .aluB(aluB), .writeData(writeData), .writeReg(writeReg)
    );

    alu u_alu (.a(aluA), .b(aluB), .func(aluFuncE), .result(aluResult), .overflow(aluOverflow));

    multDiv u_multDiv (.a(aluA), .b(aluB), .op(opE), .hi(hi), .lo(lo), .active(mdActive));

    // return address skips the delay slot
    assign aluOut = jumpE ? (pcPlus4E + word_t'(4)) : aluResult;

    // a bubble never reports overflow
    assign overflow  = aluOverflow & validE;
    assign regWrite  = regWriteE & validE & ~overflow;
    assign hiLoWrite = mdActive & validE;

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage import mips_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       flushE,
    input  logic       validD,
    input  aluFunc_t   aluFuncD,
    input  aluSrcB_t   aluSrcBD,
    input  logic       shamtValidD,
    input  regDst_t    regDstD,
    input  logic       jumpD,
    input  logic       regWriteD,
    input  decodedOp_t opD,
    input  regAddr_t   rsD,
    input  regAddr_t   rtD,
    input  regAddr_t   rdD,
    input  logic [4:0] shamtD,
    input  word_t      immD,
    input  word_t      srcAD,
    input  word_t      srcBD,
    input  word_t      pcPlus4D,
    input  word_t      resultW,
    input  regAddr_t   writeRegW,
    input  logic       regWriteW,
    output logic       validM,
    output word_t      aluOutM,
    output word_t      writeDataM,
    output regAddr_t   writeRegM,
    output logic       regWriteM,
    output word_t      hiM,
    output word_t      loM,
    output logic       hiLoWriteM,
    output logic       overflowM
);

    // decode-to-execute register contents
    logic       validE;
    logic       regWriteE;
    aluFunc_t   aluFuncE;
    aluSrcB_t   aluSrcBE;
    logic       shamtValidE;
    regDst_t    regDstE;
    logic       jumpE;
    decodedOp_t opE;
    regAddr_t   rsE;
    regAddr_t   rtE;
    regAddr_t   rdE;
    logic [4:0] shamtE;
    word_t      immE;
    word_t      srcAE;
    word_t      srcBE;
    word_t      pcPlus4E;

    forward_t forwardA;
    forward_t forwardB;

    // execute results, captured into the M register
    word_t    aluOutX;
    word_t    writeDataX;
    regAddr_t writeRegX;
    logic     regWriteX;
    word_t    hiX;
    word_t    loX;
    logic     hiLoWriteX;
    logic     overflowX;

    // flush turns the slot into a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validE    <= 1'b0;
            regWriteE <= 1'b0;
        end else begin
            validE    <= validD & ~flushE;
            regWriteE <= regWriteD & ~flushE;
        end
    end

    always_ff @(posedge clk) begin
        aluFuncE    <= aluFuncD;
        aluSrcBE    <= aluSrcBD;
        shamtValidE <= shamtValidD;
        regDstE     <= regDstD;
        jumpE       <= jumpD;
        opE         <= opD;
        rsE         <= rsD;
        rtE         <= rtD;
        rdE         <= rdD;
        shamtE      <= shamtD;
        immE        <= immD;
        srcAE       <= srcAD;
        srcBE       <= srcBD;
        pcPlus4E    <= pcPlus4D;
    end

    forwardUnit u_forwardUnit (
        .rsE(rsE), .rtE(rtE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .regWriteM(regWriteM), .regWriteW(regWriteW),
        .forwardA(forwardA), .forwardB(forwardB)
    );

    execute u_execute (
        .validE(validE), .aluFuncE(aluFuncE), .aluSrcBE(aluSrcBE), .shamtValidE(shamtValidE),
        .regDstE(regDstE), .jumpE(jumpE), .regWriteE(regWriteE), .opE(opE),
        .rtE(rtE), .rdE(rdE), .shamtE(shamtE), .immE(immE), .srcAE(srcAE), .srcBE(srcBE),
        .pcPlus4E(pcPlus4E), .forwardA(forwardA), .forwardB(forwardB),
        .aluOutM(aluOutM), .resultW(resultW),
        .aluOut(aluOutX), .writeData(writeDataX), .writeReg(writeRegX), .regWrite(regWriteX),
        .hi(hiX), .lo(loX), .hiLoWrite(hiLoWriteX), .overflow(overflowX)
    );

    // execute-to-memory control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validM     <= 1'b0;
            regWriteM  <= 1'b0;
            hiLoWriteM <= 1'b0;
            overflowM  <= 1'b0;
        end else begin
            validM     <= validE;
            regWriteM  <= regWriteX;
            hiLoWriteM <= hiLoWriteX;
            overflowM  <= overflowX;
        end
    end

    always_ff @(posedge clk) begin
        aluOutM    <= aluOutX;
        writeDataM <= writeDataX;
        writeRegM  <= writeRegX;
        hiM        <= hiX;
        loM        <= loX;
    end

endmodule

//--- logic/forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit import mips_pkg::*; (
    input  regAddr_t rsE,
    input  regAddr_t rtE,
    input  regAddr_t writeRegM,
    input  regAddr_t writeRegW,
    input  logic     regWriteM,
    input  logic     regWriteW,
    output forward_t forwardA,
    output forward_t forwardB
);

    // memory stage is younger, so it wins over writeback
    function automatic forward_t pickSource(input regAddr_t src);
        forward_t sel;
        sel = fwdNone;
        if (regWriteM && (writeRegM != '0) && (writeRegM == src)) begin
            sel = fwdMem;
        end else if (regWriteW && (writeRegW != '0) && (writeRegW == src)) begin
            sel = fwdWb;
        end
        return sel;
    endfunction

    assign forwardA = pickSource(rsE);
    assign forwardB = pickSource(rtE);

endmodule

//--- logic/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath word width
`define MIPS_WORD_BITS 32

// register number width, 32 GPRs
`define MIPS_REG_BITS 5

// jal / bal write the return address here
`define MIPS_LINK_REG 31

// set to 0 to build without the multiply/divide unit
`define MIPS_HAS_MULTDIV 1

`endif

//--- logic/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

    // basic datapath types
    typedef logic [`MIPS_WORD_BITS-1:0] word_t;
    typedef logic [`MIPS_REG_BITS-1:0] regAddr_t;

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd,
        aluAddu,
        aluSub,
        aluSubu,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu,
        aluLui
    } aluFunc_t;

    // second ALU operand source
    typedef enum logic {
        srcBReg,
        srcBImm
    } aluSrcB_t;

    // destination field of the instruction
    typedef enum logic {
        regDstRt,
        regDstRd
    } regDst_t;

    // where a source operand comes from
    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } forward_t;

    // multiply/divide ops, everything else is opNone
    typedef enum logic [2:0] {
        opNone,
        opMult,
        opMultu,
        opDiv,
        opDivu
    } decodedOp_t;

endpackage

//--- logic/multDiv.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module multDiv import mips_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  decodedOp_t op,
    output word_t      hi,
    output word_t      lo,
    output logic       active
);

    generate
        if (`MIPS_HAS_MULTDIV != 0) begin : genMultDiv
            logic [2*`MIPS_WORD_BITS-1:0] product;

            always_comb begin
                product = '0;
                hi      = '0;
                lo      = '0;
                case (op)
                    opMult: begin
                        product = $signed(a) * $signed(b);
                        {hi, lo} = product;
                    end
                    opMultu: begin
                        product = a * b;
                        {hi, lo} = product;
                    end
                    // remainder to hi, quotient to lo; zero divisor leaves zeros
                    opDiv: begin
                        if (b != '0) begin
                            hi = word_t'($signed(a) % $signed(b));
                            lo = word_t'($signed(a) / $signed(b));
                        end
                    end
                    opDivu: begin
                        if (b != '0) begin
                            hi = a % b;
                            lo = a / b;
                        end
                    end
                    default: ;
                endcase
            end

            assign active = (op != opNone);
        end else begin : genNoMultDiv
            // unit absent
            assign hi     = '0;
            assign lo     = '0;
            assign active = 1'b0;
        end
    endgenerate

endmodule

//--- logic/operandSelect.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module operandSelect import mips_pkg::*; (
    input  word_t    srcA,
    input  word_t    srcB,
    input  word_t    aluOutM,
    input  word_t    resultW,
    input  word_t    imm,
    input  forward_t forwardA,
    input  forward_t forwardB,
    input  logic [4:0] shamt,
    input  logic     shamtValid,
    input  aluSrcB_t aluSrcB,
    input  regAddr_t rt,
    input  regAddr_t rd,
    input  regDst_t  regDst,
    input  logic     jump,
    output word_t    aluA,
    output word_t    aluB,
    output word_t    writeData,
    output regAddr_t writeReg
);

    word_t fwdA;
    word_t fwdB;

    // source A forwarding
    always_comb begin
        case (forwardA)
            fwdMem:  fwdA = aluOutM;
            fwdWb:   fwdA = resultW;
            default: fwdA = srcA;
        endcase
    end

    // source B forwarding, also the store data
    always_comb begin
        case (forwardB)
            fwdMem:  fwdB = aluOutM;
            fwdWb:   fwdB = resultW;
            default: fwdB = srcB;
        endcase
    end

    assign writeData = fwdB;

    // shift instructions take the shamt field as operand a
    assign aluA = shamtValid ? {{(`MIPS_WORD_BITS-5){1'b0}}, shamt} : fwdA;

    assign aluB = (aluSrcB == srcBImm) ? imm : fwdB;

    // jumps and branches with link go to $ra
    always_comb begin
        if (jump) begin
            writeReg = regAddr_t'(`MIPS_LINK_REG);
        end else begin
            writeReg = (regDst == regDstRd) ? rd : rt;
        end
    end

endmodule

//--- verification/executeStageTb.sv
`timescale 1ns/1ps

module executeStageTb import mips_pkg::*; ();

    localparam int clkPeriod = 10;
    localparam int maxRows = 40;

    // row mode bits
    localparam logic [5:0] modeRt = 6'd0;
    localparam logic [5:0] modeImm = 6'd1;
    localparam logic [5:0] modeShamt = 6'd2;
    localparam logic [5:0] modeRd = 6'd4;
    localparam logic [5:0] modeJump = 6'd8;
    localparam logic [5:0] modeFlush = 6'd16;
    localparam logic [5:0] modeNoWrite = 6'd32;

    // expected {validM, regWriteM, hiLoWriteM, overflowM}
    localparam logic [3:0] flagsWrite = 4'b1100;
    localparam logic [3:0] flagsHiLo = 4'b1010;
    localparam logic [3:0] flagsOverflow = 4'b1001;
    localparam logic [3:0] flagsBubble = 4'b0000;

    logic       clk;
    logic       rstN;
    logic       flushE;
    logic       validD;
    aluFunc_t   aluFuncD;
    aluSrcB_t   aluSrcBD;
    logic       shamtValidD;
    regDst_t    regDstD;
    logic       jumpD;
    logic       regWriteD;
    decodedOp_t opD;
    regAddr_t   rsD;
    regAddr_t   rtD;
    regAddr_t   rdD;
    logic [4:0] shamtD;
    word_t      immD;
    word_t      srcAD;
    word_t      srcBD;
    word_t      pcPlus4D;
    word_t      resultW;
    regAddr_t   writeRegW;
    logic       regWriteW;
    logic       validM;
    word_t      aluOutM;
    word_t      writeDataM;
    regAddr_t   writeRegM;
    logic       regWriteM;
    word_t      hiM;
    word_t      loM;
    logic       hiLoWriteM;
    logic       overflowM;

    // stimulus and expected table
    string      rowName [maxRows];
    aluFunc_t   rowFunc [maxRows];
    decodedOp_t rowOp [maxRows];
    logic [5:0] rowMode [maxRows];
    regAddr_t   rowRs [maxRows];
    regAddr_t   rowRt [maxRows];
    regAddr_t   rowRd [maxRows];
    logic [4:0] rowShamt [maxRows];
    word_t      rowImm [maxRows];
    word_t      rowSrcA [maxRows];
    word_t      rowSrcB [maxRows];
    word_t      rowPc [maxRows];
    word_t      rowResultW [maxRows];
    regAddr_t   rowWriteRegW [maxRows];
    logic       rowRegWriteW [maxRows];
    word_t      expAluOut [maxRows];
    word_t      expWriteData [maxRows];
    regAddr_t   expWriteReg [maxRows];
    word_t      expHi [maxRows];
    word_t      expLo [maxRows];
    logic [3:0] expFlags [maxRows];

    int   numRows = 0;
    int   errorCount = 0;
    logic tableBuilt = 1'b0;

    executeStage i_dut (
        .clk(clk), .rstN(rstN), .flushE(flushE), .validD(validD), .aluFuncD(aluFuncD),
        .aluSrcBD(aluSrcBD), .shamtValidD(shamtValidD), .regDstD(regDstD), .jumpD(jumpD),
        .regWriteD(regWriteD), .opD(opD), .rsD(rsD), .rtD(rtD), .rdD(rdD), .shamtD(shamtD),
        .immD(immD), .srcAD(srcAD), .srcBD(srcBD), .pcPlus4D(pcPlus4D), .resultW(resultW),
        .writeRegW(writeRegW), .regWriteW(regWriteW), .validM(validM), .aluOutM(aluOutM),
        .writeDataM(writeDataM), .writeRegM(writeRegM), .regWriteM(regWriteM), .hiM(hiM),
        .loM(loM), .hiLoWriteM(hiLoWriteM), .overflowM(overflowM)
    );

    bind executeStage executeStageChecker u_checker (
        .clk(clk), .rstN(rstN), .validM(validM), .regWriteM(regWriteM),
        .hiLoWriteM(hiLoWriteM), .overflowM(overflowM)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic addRow(input string name, input aluFunc_t func, input decodedOp_t op,
                          input logic [5:0] mode, input regAddr_t rs, rt, rd,
                          input logic [4:0] shamt, input word_t imm, srcA, srcB, pcPlus4,
                          input word_t aluOut, writeData, input regAddr_t writeReg,
                          input word_t hi, lo, input logic [3:0] flags);
        rowName[numRows] = name;
        rowFunc[numRows] = func;
        rowOp[numRows] = op;
        rowMode[numRows] = mode;
        rowRs[numRows] = rs;
        rowRt[numRows] = rt;
        rowRd[numRows] = rd;
        rowShamt[numRows] = shamt;
        rowImm[numRows] = imm;
        rowSrcA[numRows] = srcA;
        rowSrcB[numRows] = srcB;
        rowPc[numRows] = pcPlus4;
        rowResultW[numRows] = '0;
        rowWriteRegW[numRows] = '0;
        rowRegWriteW[numRows] = 1'b0;
        expAluOut[numRows] = aluOut;
        expWriteData[numRows] = writeData;
        expWriteReg[numRows] = writeReg;
        expHi[numRows] = hi;
        expLo[numRows] = lo;
        expFlags[numRows] = flags;
        numRows++;
    endtask

    // writeback feedback seen while the last added row is in execute
    task automatic setWriteback(input word_t result, input regAddr_t writeReg);
        rowResultW[numRows - 1] = result;
        rowWriteRegW[numRows - 1] = writeReg;
        rowRegWriteW[numRows - 1] = 1'b1;
    endtask

    task automatic buildTable();
        addRow("add_rd", aluAdd, opNone, modeRd, 5'd1, 5'd2, 5'd10, 5'd0, 32'h0,
               32'h0000_1234, 32'h0000_0100, 32'h0,
               32'h0000_1334, 32'h0000_0100, 5'd10, 32'h0, 32'h0, flagsWrite);
        addRow("sub_rt", aluSub, opNone, modeRt, 5'd3, 5'd4, 5'd11, 5'd0, 32'h0,
               32'h0000_0100, 32'h0000_0030, 32'h0,
               32'h0000_00d0, 32'h0000_0030, 5'd4, 32'h0, 32'h0, flagsWrite);
        addRow("and_rd", aluAnd, opNone, modeRd, 5'd5, 5'd6, 5'd12, 5'd0, 32'h0,
               32'hf0f0_1234, 32'h0ff0_ff00, 32'h0,
               32'h00f0_1200, 32'h0ff0_ff00, 5'd12, 32'h0, 32'h0, flagsWrite);
        addRow("or_rd", aluOr, opNone, modeRd, 5'd7, 5'd8, 5'd13, 5'd0, 32'h0,
               32'hf000_000f, 32'h0000_0f00, 32'h0,
               32'hf000_0f0f, 32'h0000_0f00, 5'd13, 32'h0, 32'h0, flagsWrite);
        addRow("xor_rt", aluXor, opNone, modeRt, 5'd1, 5'd9, 5'd14, 5'd0, 32'h0,
               32'hffff_0000, 32'h0f0f_0f0f, 32'h0,
               32'hf0f0_0f0f, 32'h0f0f_0f0f, 5'd9, 32'h0, 32'h0, flagsWrite);
        addRow("nor_rd", aluNor, opNone, modeRd, 5'd2, 5'd3, 5'd15, 5'd0, 32'h0,
               32'h0000_00ff, 32'h0000_ff00, 32'h0,
               32'hffff_0000, 32'h0000_ff00, 5'd15, 32'h0, 32'h0, flagsWrite);
        addRow("slt_rd", aluSlt, opNone, modeRd, 5'd1, 5'd2, 5'd16, 5'd0, 32'h0,
               32'hffff_fffe, 32'h0000_0001, 32'h0,
               32'h0000_0001, 32'h0000_0001, 5'd16, 32'h0, 32'h0, flagsWrite);
        addRow("sltu_rd", aluSltu, opNone, modeRd, 5'd1, 5'd2, 5'd17, 5'd0, 32'h0,
               32'hffff_fffe, 32'h0000_0001, 32'h0,
               32'h0000_0000, 32'h0000_0001, 5'd17, 32'h0, 32'h0, flagsWrite);
        addRow("subu_rd", aluSubu, opNone, modeRd, 5'd3, 5'd4, 5'd18, 5'd0, 32'h0,
               32'h0000_0005, 32'h0000_0007, 32'h0,
               32'hffff_fffe, 32'h0000_0007, 5'd18, 32'h0, 32'h0, flagsWrite);
        // immediate operand b, store data still from rt
        addRow("addu_imm", aluAddu, opNone, modeImm, 5'd5, 5'd19, 5'd0, 5'd0, 32'hffff_fff0,
               32'h0000_0100, 32'hdead_beef, 32'h0,
               32'h0000_00f0, 32'hdead_beef, 5'd19, 32'h0, 32'h0, flagsWrite);
        addRow("lui_imm", aluLui, opNone, modeImm, 5'd0, 5'd20, 5'd0, 5'd0, 32'h0000_abcd,
               32'h0000_0000, 32'h1111_1111, 32'h0,
               32'habcd_0000, 32'h1111_1111, 5'd20, 32'h0, 32'h0, flagsWrite);
        // shamt replaces source a
        addRow("sll_shamt", aluSll, opNone, modeShamt | modeRd, 5'd0, 5'd6, 5'd21, 5'd4, 32'h0,
               32'h5555_5555, 32'h0000_00f1, 32'h0,
               32'h0000_0f10, 32'h0000_00f1, 5'd21, 32'h0, 32'h0, flagsWrite);
        addRow("srl_shamt", aluSrl, opNone, modeShamt | modeRd, 5'd0, 5'd7, 5'd22, 5'd8, 32'h0,
               32'h5555_5555, 32'h8000_ff00, 32'h0,
               32'h0080_00ff, 32'h8000_ff00, 5'd22, 32'h0, 32'h0, flagsWrite);
        addRow("sra_shamt", aluSra, opNone, modeShamt | modeRd, 5'd0, 5'd8, 5'd23, 5'd4, 32'h0,
               32'h5555_5555, 32'h8000_0000, 32'h0,
               32'hf800_0000, 32'h8000_0000, 5'd23, 32'h0, 32'h0, flagsWrite);
        addRow("add_ovf", aluAdd, opNone, modeRd, 5'd1, 5'd2, 5'd24, 5'd0, 32'h0,
               32'h7fff_ffff, 32'h0000_0001, 32'h0,
               32'h8000_0000, 32'h0000_0001, 5'd24, 32'h0, 32'h0, flagsOverflow);
        addRow("addu_no_ovf", aluAddu, opNone, modeRd, 5'd1, 5'd2, 5'd25, 5'd0, 32'h0,
               32'h7fff_ffff, 32'h0000_0001, 32'h0,
               32'h8000_0000, 32'h0000_0001, 5'd25, 32'h0, 32'h0, flagsWrite);
        // stale register values must lose to forwarded results
        addRow("fwd_mem_a", aluAddu, opNone, modeRd, 5'd25, 5'd3, 5'd26, 5'd0, 32'h0,
               32'h1111_1111, 32'h0000_0010, 32'h0,
               32'h8000_0010, 32'h0000_0010, 5'd26, 32'h0, 32'h0, flagsWrite);
        addRow("fwd_mem_b", aluOr, opNone, modeRd, 5'd4, 5'd26, 5'd27, 5'd0, 32'h0,
               32'h0000_0001, 32'h2222_2222, 32'h0,
               32'h8000_0011, 32'h8000_0010, 5'd27, 32'h0, 32'h0, flagsWrite);
        addRow("fwd_wb_a", aluAddu, opNone, modeRd, 5'd26, 5'd5, 5'd28, 5'd0, 32'h0,
               32'h3333_3333, 32'h0000_0001, 32'h0,
               32'h8000_0011, 32'h0000_0001, 5'd28, 32'h0, 32'h0, flagsWrite);
        setWriteback(32'h8000_0010, 5'd26);
        addRow("fwd_mem_wins", aluSubu, opNone, modeRd, 5'd28, 5'd6, 5'd29, 5'd0, 32'h0,
               32'h4444_4444, 32'h0000_0011, 32'h0,
               32'h8000_0000, 32'h0000_0011, 5'd29, 32'h0, 32'h0, flagsWrite);
        setWriteback(32'hbad0_0000, 5'd28);
        addRow("write_zero", aluAddu, opNone, modeRd, 5'd1, 5'd2, 5'd0, 5'd0, 32'h0,
               32'h0000_0055, 32'h0000_0022, 32'h0,
               32'h0000_0077, 32'h0000_0022, 5'd0, 32'h0, 32'h0, flagsWrite);
        addRow("zero_no_fwd", aluAddu, opNone, modeRd, 5'd0, 5'd0, 5'd30, 5'd0, 32'h0,
               32'h0000_0000, 32'h0000_0000, 32'h0,
               32'h0000_0000, 32'h0000_0000, 5'd30, 32'h0, 32'h0, flagsWrite);
        setWriteback(32'hffff_ffff, 5'd0);
        addRow("jal_link", aluAddu, opNone, modeJump, 5'd0, 5'd0, 5'd0, 5'd0, 32'h0,
               32'h0000_0000, 32'h0000_0000, 32'h0040_0100,
               32'h0040_0104, 32'h0000_0000, 5'd31, 32'h0, 32'h0, flagsWrite);
        addRow("mult", aluAddu, opMult, modeNoWrite, 5'd1, 5'd2, 5'd0, 5'd0, 32'h0,
               32'hffff_fffe, 32'h0000_0003, 32'h0,
               32'h0000_0001, 32'h0000_0003, 5'd2, 32'hffff_ffff, 32'hffff_fffa, flagsHiLo);
        addRow("multu", aluAddu, opMultu, modeNoWrite, 5'd1, 5'd2, 5'd0, 5'd0, 32'h0,
               32'hffff_fffe, 32'h0000_0003, 32'h0,
               32'h0000_0001, 32'h0000_0003, 5'd2, 32'h0000_0002, 32'hffff_fffa, flagsHiLo);
        addRow("div", aluAddu, opDiv, modeNoWrite, 5'd1, 5'd2, 5'd0, 5'd0, 32'h0,
               32'hffff_fff9, 32'h0000_0002, 32'h0,
               32'hffff_fffb, 32'h0000_0002, 5'd2, 32'hffff_ffff, 32'hffff_fffd, flagsHiLo);
        addRow("divu", aluAddu, opDivu, modeNoWrite, 5'd1, 5'd2, 5'd0, 5'd0, 32'h0,
               32'h0000_0064, 32'h0000_0007, 32'h0,
               32'h0000_006b, 32'h0000_0007, 5'd2, 32'h0000_0002, 32'h0000_000e, flagsHiLo);
        addRow("div_by_zero", aluAddu, opDiv, modeNoWrite, 5'd1, 5'd2, 5'd0, 5'd0, 32'h0,
               32'h0000_1234, 32'h0000_0000, 32'h0,
               32'h0000_1234, 32'h0000_0000, 5'd2, 32'h0, 32'h0, flagsHiLo);
        addRow("flushed_add", aluAddu, opNone, modeRd | modeFlush, 5'd1, 5'd2, 5'd9, 5'd0, 32'h0,
               32'h0000_0005, 32'h0000_0006, 32'h0,
               32'h0000_000b, 32'h0000_0006, 5'd9, 32'h0, 32'h0, flagsBubble);
        // a bubble in M must not forward
        addRow("after_flush", aluAddu, opNone, modeRd, 5'd9, 5'd2, 5'd10, 5'd0, 32'h0,
               32'h0000_0020, 32'h0000_0001, 32'h0,
               32'h0000_0021, 32'h0000_0001, 5'd10, 32'h0, 32'h0, flagsWrite);
    endtask

    task automatic initInputs();
        rstN = 1'b0;
        flushE = 1'b0;
        validD = 1'b0;
        aluFuncD = aluAdd;
        aluSrcBD = srcBReg;
        shamtValidD = 1'b0;
        regDstD = regDstRt;
        jumpD = 1'b0;
        regWriteD = 1'b0;
        opD = opNone;
        rsD = '0;
        rtD = '0;
        rdD = '0;
        shamtD = '0;
        immD = '0;
        srcAD = '0;
        srcBD = '0;
        pcPlus4D = '0;
        resultW = '0;
        writeRegW = '0;
        regWriteW = 1'b0;
    endtask

    task automatic driveRow(input int idx);
        if (idx < numRows) begin
            validD <= 1'b1;
            flushE <= rowMode[idx][4];
            aluFuncD <= rowFunc[idx];
            aluSrcBD <= rowMode[idx][0] ? srcBImm : srcBReg;
            shamtValidD <= rowMode[idx][1];
            regDstD <= rowMode[idx][2] ? regDstRd : regDstRt;
            jumpD <= rowMode[idx][3];
            regWriteD <= ~rowMode[idx][5];
            opD <= rowOp[idx];
            rsD <= rowRs[idx];
            rtD <= rowRt[idx];
            rdD <= rowRd[idx];
            shamtD <= rowShamt[idx];
            immD <= rowImm[idx];
            srcAD <= rowSrcA[idx];
            srcBD <= rowSrcB[idx];
            pcPlus4D <= rowPc[idx];
        end else begin
            // idle slot once the table is used up
            validD <= 1'b0;
            flushE <= 1'b0;
            regWriteD <= 1'b0;
            opD <= opNone;
        end
    endtask

    task automatic driveWriteback(input int idx);
        if (idx >= 0 && idx < numRows) begin
            resultW <= rowResultW[idx];
            writeRegW <= rowWriteRegW[idx];
            regWriteW <= rowRegWriteW[idx];
        end else begin
            resultW <= '0;
            writeRegW <= '0;
            regWriteW <= 1'b0;
        end
    endtask

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: %s expected %h actual %h", testName, field, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic checkOutputs(input int idx);
        checkValue(rowName[idx], "validM", expFlags[idx][3], validM);
        checkValue(rowName[idx], "regWriteM", expFlags[idx][2], regWriteM);
        checkValue(rowName[idx], "hiLoWriteM", expFlags[idx][1], hiLoWriteM);
        checkValue(rowName[idx], "overflowM", expFlags[idx][0], overflowM);
        checkValue(rowName[idx], "aluOutM", expAluOut[idx], aluOutM);
        checkValue(rowName[idx], "writeDataM", expWriteData[idx], writeDataM);
        checkValue(rowName[idx], "writeRegM", expWriteReg[idx], writeRegM);
        checkValue(rowName[idx], "hiM", expHi[idx], hiM);
        checkValue(rowName[idx], "loM", expLo[idx], loM);
    endtask

    initial begin
        initInputs();
        buildTable();
        tableBuilt = 1'b1;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        // row i enters at this edge, feedback for row i-1 is in execute now
        for (int i = 0; i < numRows + 2; i++) begin
            @(posedge clk);
            driveRow(i);
            driveWriteback(i - 1);
            @(negedge clk);
            if (i >= 2) begin
                checkOutputs(i - 2);
            end
        end
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (tableBuilt);
        repeat (numRows + 10) @(posedge clk);
        $display("Timeout: the table was not fully checked within %0d cycles", numRows + 10);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (i_dut.u_checker.failCount != 0);
        $display("An assertion on the memory-stage outputs failed in the bound checker");
        $display("Test failures found");
        $fatal(1, "checker assertion failed");
    end

endmodule

//--- verification/executeStage_checker.sv
`timescale 1ns/1ps

module executeStageChecker (
    input logic clk,
    input logic rstN,
    input logic validM,
    input logic regWriteM,
    input logic hiLoWriteM,
    input logic overflowM
);

    // number of failed assertions so far
    int failCount = 0;

    // first edge out of reset still holds a bubble in M
    assert property (@(posedge clk) $rose(rstN) |-> !validM)
        else begin
            $error("validM high right after reset release");
            failCount++;
        end

    // write enables only travel with a valid instruction
    assert property (@(posedge clk) disable iff (!rstN) regWriteM |-> validM)
        else begin
            $error("regWriteM set for an invalid slot");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (!rstN) hiLoWriteM |-> validM)
        else begin
            $error("hiLoWriteM set for an invalid slot");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (!rstN) overflowM |-> validM)
        else begin
            $error("overflowM set for an invalid slot");
            failCount++;
        end

    // an overflowing add or sub must not write its destination
    assert property (@(posedge clk) disable iff (!rstN) overflowM |-> !regWriteM)
        else begin
            $error("regWriteM still set on overflow");
            failCount++;
        end

endmodule
